/* hw/core_cfg.svh */
// Core configuration constants
// Bridge address map, save buffer geometry and reset hold length

`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// bridge address bits 31:28 that select the save area
`define SAVE_REGION 4'h2

// half-word index width into the save buffer (512 entries)
`define SAVE_ADDR_WIDTH 9

// reload value for the reset hold counter
`define RESET_HOLD_CYCLES 32'd64

////////////////////
// settings addresses
`define ADDR_SGX 32'h0000_0004
`define ADDR_RESET 32'h0000_0050
`define ADDR_TURBO_TAP 32'h0000_0100
`define ADDR_OVERSCAN 32'h0000_0200
`define ADDR_EXTRA_SPRITES 32'h0000_0204

`endif

/* hw/core_pkg.sv */
// Core package
// Shared vector types and FSM encodings for the bridge side of the core

`default_nettype none

`include "core_cfg.svh"

package core_pkg;

  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_word_t;
  typedef logic [15:0] save_half_t;
  typedef logic [`SAVE_ADDR_WIDTH-1:0] save_addr_t;
  typedef logic [31:0] hold_count_t;

  // bridge write into two half-word handshakes
  typedef enum logic [2:0] {
    LD_IDLE,
    LD_REQ_HI,
    LD_WAIT_HI,
    LD_REQ_LO,
    LD_WAIT_LO
  } loader_state_t;

  // bridge read from two half-word handshakes
  typedef enum logic [2:0] {
    UL_IDLE,
    UL_REQ_HI,
    UL_WAIT_HI,
    UL_REQ_LO,
    UL_WAIT_LO
  } unloader_state_t;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_ACCESS,
    ARB_ACK
  } arb_state_t;

endpackage

`default_nettype wire

/* hw/bridge_settings.sv */
// Bridge settings registers
// Host writes set the core option flags; a reset command starts
// a fixed-length core reset hold

`default_nettype none

`include "core_cfg.svh"

module bridge_settings (
  input  logic                  clk_74a,
  input  logic                  pll_core_locked,
  input  core_pkg::bridge_addr_t bridge_addr,
  input  logic                  bridge_wr,
  input  core_pkg::bridge_word_t bridge_wr_data,
  output logic                  is_sgx,
  output logic                  turbo_tap_enable,
  output logic                  overscan_enable,
  output logic                  extra_sprites_enable,
  output logic                  core_reset
);

  core_pkg::hold_count_t hold_count;

  ////////////////////
  // option flags from bit 0 of the write data
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      is_sgx               <= 1'b0;
      turbo_tap_enable     <= 1'b0;
      overscan_enable      <= 1'b0;
      extra_sprites_enable <= 1'b0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        `ADDR_SGX:           is_sgx <= bridge_wr_data[0];
        `ADDR_TURBO_TAP:     turbo_tap_enable <= bridge_wr_data[0];
        `ADDR_OVERSCAN:      overscan_enable <= bridge_wr_data[0];
        `ADDR_EXTRA_SPRITES: extra_sprites_enable <= bridge_wr_data[0];
        default: ;
      endcase
    end
  end

  ////////////////////
  // reset hold counter counts down to zero
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hold_count <= '0;
    end else if (bridge_wr && bridge_addr == `ADDR_RESET) begin
      hold_count <= `RESET_HOLD_CYCLES;
    end else if (hold_count != '0) begin
      hold_count <= hold_count - 32'd1;
    end
  end

  // held while any count remains
  assign core_reset = (hold_count != '0);

endmodule

`default_nettype wire

/* hw/save_loader.sv */
// Save data loader
// Splits a 32-bit bridge save write into two half-word handshakes,
// high half first, toward the save arbiter

`default_nettype none

`include "core_cfg.svh"

module save_loader (
  input  logic                   clk_74a,
  input  logic                   pll_core_locked,
  input  core_pkg::bridge_addr_t bridge_addr,
  input  logic                   bridge_wr,
  input  core_pkg::bridge_word_t bridge_wr_data,
  output logic                   ld_req,
  input  logic                   ld_ack,
  output core_pkg::save_addr_t   ld_addr,
  output core_pkg::save_half_t   ld_data,
  output logic                   busy
);

  core_pkg::loader_state_t state;
  core_pkg::bridge_word_t  word_q;
  logic [`SAVE_ADDR_WIDTH-2:0] word_idx;
  logic save_wr;
  logic lo_phase;

  assign save_wr = bridge_wr && (bridge_addr[31:28] == `SAVE_REGION);

  // word and offset captured only while idle
  always_ff @(posedge clk_74a) begin
    if (state == core_pkg::LD_IDLE && save_wr) begin
      word_q   <= bridge_wr_data;
      word_idx <= bridge_addr[`SAVE_ADDR_WIDTH:2];
    end
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      state <= core_pkg::LD_IDLE;
    end else begin
      case (state)
        core_pkg::LD_IDLE:    if (save_wr) state <= core_pkg::LD_REQ_HI;
        core_pkg::LD_REQ_HI:  if (ld_ack) state <= core_pkg::LD_WAIT_HI;
        core_pkg::LD_WAIT_HI: if (!ld_ack) state <= core_pkg::LD_REQ_LO;
        core_pkg::LD_REQ_LO:  if (ld_ack) state <= core_pkg::LD_WAIT_LO;
        core_pkg::LD_WAIT_LO: if (!ld_ack) state <= core_pkg::LD_IDLE;
        default:              state <= core_pkg::LD_IDLE;
      endcase
    end
  end

  // big-endian so the upper half goes to the even index
  assign lo_phase = (state == core_pkg::LD_REQ_LO) || (state == core_pkg::LD_WAIT_LO);
  assign ld_req   = (state == core_pkg::LD_REQ_HI) || (state == core_pkg::LD_REQ_LO);
  assign ld_addr  = {word_idx, lo_phase};
  assign ld_data  = lo_phase ? word_q[15:0] : word_q[31:16];
  assign busy     = (state != core_pkg::LD_IDLE);

endmodule

`default_nettype wire

/* hw/save_unloader.sv */
// Save data unloader
// Fetches two half-words for a bridge save read and holds the
// assembled word for the bridge read mux

`default_nettype none

`include "core_cfg.svh"

module save_unloader (
  input  logic                   clk_74a,
  input  logic                   pll_core_locked,
  input  core_pkg::bridge_addr_t bridge_addr,
  input  logic                   bridge_rd,
  output logic                   ul_req,
  input  logic                   ul_ack,
  output core_pkg::save_addr_t   ul_addr,
  input  core_pkg::save_half_t   ul_rdata,
  output core_pkg::bridge_word_t rd_word,
  output logic                   busy
);

  core_pkg::unloader_state_t state;
  core_pkg::save_half_t      hi_half;
  logic [`SAVE_ADDR_WIDTH-2:0] word_idx;
  logic save_rd;
  logic lo_phase;

  assign save_rd = bridge_rd && (bridge_addr[31:28] == `SAVE_REGION);

  always_ff @(posedge clk_74a) begin
    if (state == core_pkg::UL_IDLE && save_rd) begin
      word_idx <= bridge_addr[`SAVE_ADDR_WIDTH:2];
    end
    // upper half parked until the lower one arrives
    if (state == core_pkg::UL_REQ_HI && ul_ack) begin
      hi_half <= ul_rdata;
    end
  end

  ////////////////////
  // handshake walk
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      state <= core_pkg::UL_IDLE;
    end else begin
      case (state)
        core_pkg::UL_IDLE:    if (save_rd) state <= core_pkg::UL_REQ_HI;
        core_pkg::UL_REQ_HI:  if (ul_ack) state <= core_pkg::UL_WAIT_HI;
        core_pkg::UL_WAIT_HI: if (!ul_ack) state <= core_pkg::UL_REQ_LO;
        core_pkg::UL_REQ_LO:  if (ul_ack) state <= core_pkg::UL_WAIT_LO;
        core_pkg::UL_WAIT_LO: if (!ul_ack) state <= core_pkg::UL_IDLE;
        default:              state <= core_pkg::UL_IDLE;
      endcase
    end
  end

  // whole word swapped in at once so the host never sees a torn value
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      rd_word <= '0;
    end else if (state == core_pkg::UL_REQ_LO && ul_ack) begin
      rd_word <= {hi_half, ul_rdata};
    end
  end

  assign lo_phase = (state == core_pkg::UL_REQ_LO) || (state == core_pkg::UL_WAIT_LO);
  assign ul_req   = (state == core_pkg::UL_REQ_HI) || (state == core_pkg::UL_REQ_LO);
  assign ul_addr  = {word_idx, lo_phase};
  assign busy     = (state != core_pkg::UL_IDLE);

endmodule

`default_nettype wire

/* hw/save_arbiter.sv */
// Save buffer arbiter
// Grants the single buffer port to the loader or the unloader,
// one four-phase transaction at a time, loader first

`default_nettype none

module save_arbiter (
  input  logic                 clk_74a,
  input  logic                 pll_core_locked,
  input  logic                 ld_req,
  output logic                 ld_ack,
  input  core_pkg::save_addr_t ld_addr,
  input  core_pkg::save_half_t ld_data,
  input  logic                 ul_req,
  output logic                 ul_ack,
  input  core_pkg::save_addr_t ul_addr,
  output core_pkg::save_half_t ul_rdata,
  output logic                 buf_en,
  output logic                 buf_we,
  output core_pkg::save_addr_t buf_addr,
  output core_pkg::save_half_t buf_wdata,
  input  core_pkg::save_half_t buf_rdata
);

  core_pkg::arb_state_t state;
  // high when the unloader owns the current transaction
  logic gnt_ul;
  logic gnt_req;

  assign gnt_req = gnt_ul ? ul_req : ld_req;

  always_ff @(posedge clk_74a) begin
    if (state == core_pkg::ARB_IDLE) begin
      buf_addr  <= ld_req ? ld_addr : ul_addr;
      buf_wdata <= ld_data;
    end
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      state  <= core_pkg::ARB_IDLE;
      gnt_ul <= 1'b0;
      buf_en <= 1'b0;
      buf_we <= 1'b0;
      ld_ack <= 1'b0;
      ul_ack <= 1'b0;
    end else begin
      case (state)
        core_pkg::ARB_IDLE: begin
          if (ld_req || ul_req) begin
            gnt_ul <= !ld_req;
            buf_en <= 1'b1;
            buf_we <= ld_req;
            state  <= core_pkg::ARB_ACCESS;
          end
        end
        // buffer access done at this edge and read data now valid
        core_pkg::ARB_ACCESS: begin
          buf_en <= 1'b0;
          buf_we <= 1'b0;
          ld_ack <= !gnt_ul;
          ul_ack <= gnt_ul;
          state  <= core_pkg::ARB_ACK;
        end
        core_pkg::ARB_ACK: begin
          if (!gnt_req) begin
            ld_ack <= 1'b0;
            ul_ack <= 1'b0;
            state  <= core_pkg::ARB_IDLE;
          end
        end
        default: state <= core_pkg::ARB_IDLE;
      endcase
    end
  end

  // buffer output holds while buf_en stays low
  assign ul_rdata = buf_rdata;

endmodule

`default_nettype wire

/* hw/save_buffer.sv */
// Save buffer
// Single-port synchronous half-word memory with registered read data

`default_nettype none

`include "core_cfg.svh"

module save_buffer (
  input  logic                 clk_74a,
  input  logic                 en,
  input  logic                 we,
  input  core_pkg::save_addr_t addr,
  input  core_pkg::save_half_t wdata,
  output core_pkg::save_half_t rdata
);

  localparam int DEPTH = 1 << `SAVE_ADDR_WIDTH;

  core_pkg::save_half_t mem [DEPTH];

  // read-first on a write cycle
  always_ff @(posedge clk_74a) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end
      rdata <= mem[addr];
    end
  end

endmodule

`default_nettype wire

/* hw/core_top.sv */
// Core top level, bridge side
// Settings registers, reset hold and the arbitrated save-data path,
// with the bridge read mux

`default_nettype none

`include "core_cfg.svh"

module core_top (
  input  logic                   clk_74a,
  input  logic                   pll_core_locked,
  input  core_pkg::bridge_addr_t bridge_addr,
  input  logic                   bridge_rd,
  input  logic                   bridge_wr,
  input  core_pkg::bridge_word_t bridge_wr_data,
  output core_pkg::bridge_word_t bridge_rd_data,
  output logic                   is_sgx,
  output logic                   turbo_tap_enable,
  output logic                   overscan_enable,
  output logic                   extra_sprites_enable,
  output logic                   core_reset,
  output logic                   save_busy
);

  logic ld_req;
  logic ld_ack;
  core_pkg::save_addr_t ld_addr;
  core_pkg::save_half_t ld_data;
  logic ld_busy;

  logic ul_req;
  logic ul_ack;
  core_pkg::save_addr_t ul_addr;
  core_pkg::save_half_t ul_rdata;
  core_pkg::bridge_word_t rd_word;
  logic ul_busy;

  logic buf_en;
  logic buf_we;
  core_pkg::save_addr_t buf_addr;
  core_pkg::save_half_t buf_wdata;
  core_pkg::save_half_t buf_rdata;

  bridge_settings u_settings (
    .clk_74a              (clk_74a),
    .pll_core_locked      (pll_core_locked),
    .bridge_addr          (bridge_addr),
    .bridge_wr            (bridge_wr),
    .bridge_wr_data       (bridge_wr_data),
    .is_sgx               (is_sgx),
    .turbo_tap_enable     (turbo_tap_enable),
    .overscan_enable      (overscan_enable),
    .extra_sprites_enable (extra_sprites_enable),
    .core_reset           (core_reset)
  );

  ////////////////////
  // save-data path
  save_loader u_loader (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge_addr     (bridge_addr),
    .bridge_wr       (bridge_wr),
    .bridge_wr_data  (bridge_wr_data),
    .ld_req          (ld_req),
    .ld_ack          (ld_ack),
    .ld_addr         (ld_addr),
    .ld_data         (ld_data),
    .busy            (ld_busy)
  );

  save_unloader u_unloader (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge_addr     (bridge_addr),
    .bridge_rd       (bridge_rd),
    .ul_req          (ul_req),
    .ul_ack          (ul_ack),
    .ul_addr         (ul_addr),
    .ul_rdata        (ul_rdata),
    .rd_word         (rd_word),
    .busy            (ul_busy)
  );

  save_arbiter u_arbiter (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .ld_req          (ld_req),
    .ld_ack          (ld_ack),
    .ld_addr         (ld_addr),
    .ld_data         (ld_data),
    .ul_req          (ul_req),
    .ul_ack          (ul_ack),
    .ul_addr         (ul_addr),
    .ul_rdata        (ul_rdata),
    .buf_en          (buf_en),
    .buf_we          (buf_we),
    .buf_addr        (buf_addr),
    .buf_wdata       (buf_wdata),
    .buf_rdata       (buf_rdata)
  );

  save_buffer u_buffer (
    .clk_74a (clk_74a),
    .en      (buf_en),
    .we      (buf_we),
    .addr    (buf_addr),
    .wdata   (buf_wdata),
    .rdata   (buf_rdata)
  );

  // only the save area is readable and everything else returns zero
  always_comb begin
    if (bridge_addr[31:28] == `SAVE_REGION) begin
      bridge_rd_data = rd_word;
    end else begin
      bridge_rd_data = '0;
    end
  end

  assign save_busy = ld_busy | ul_busy;

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
// Testbench clock and reset source
// 10 ns clk_74a, pll_core_locked held low for the first 8 cycles

`default_nettype none

module tb_clock (
  output logic clk_74a,
  output logic pll_core_locked
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_74a = 1'b0;
    forever #5 clk_74a = ~clk_74a;
  end

  // released on a falling edge away from the sampling edge
  initial begin
    pll_core_locked = 1'b0;
    repeat (8) @(posedge clk_74a);
    @(negedge clk_74a);
    pll_core_locked = 1'b1;
  end

endmodule

`default_nettype wire

/* tb/core_top_assert.sv */
// Save arbiter handshake assertions
// Four-phase req/ack rules and buffer port use, bound into save_arbiter

`default_nettype none

module core_top_assert (
  input logic clk_74a,
  input logic pll_core_locked,
  input logic ld_req,
  input logic ld_ack,
  input logic ul_req,
  input logic ul_ack,
  input logic buf_en
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  ////////////////////
  // ack only answers a pending req
  ld_ack_needs_req: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    $rose(ld_ack) |-> ld_req)
    else begin
      $error("ld_ack rose without ld_req");
      fail_count++;
    end

  ul_ack_needs_req: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    $rose(ul_ack) |-> ul_req)
    else begin
      $error("ul_ack rose without ul_req");
      fail_count++;
    end

  // one grant at a time
  acks_exclusive: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    !(ld_ack && ul_ack))
    else begin
      $error("ld_ack and ul_ack high together");
      fail_count++;
    end

  // req held until answered
  ld_req_held: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    (ld_req && !ld_ack) |=> ld_req)
    else begin
      $error("ld_req dropped before ld_ack");
      fail_count++;
    end

  ul_req_held: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    (ul_req && !ul_ack) |=> ul_req)
    else begin
      $error("ul_req dropped before ul_ack");
      fail_count++;
    end

  // buffer port idle while an ack is out
  buf_quiet_on_ack: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    (ld_ack || ul_ack) |-> !buf_en)
    else begin
      $error("buf_en high while an ack is high");
      fail_count++;
    end

endmodule

bind save_arbiter core_top_assert u_assert (
  .clk_74a         (clk_74a),
  .pll_core_locked (pll_core_locked),
  .ld_req          (ld_req),
  .ld_ack          (ld_ack),
  .ul_req          (ul_req),
  .ul_ack          (ul_ack),
  .buf_en          (buf_en)
);

`default_nettype wire

/* tb/core_top_tb.sv */
// Testbench for the bridge side of the core top level
// Table-driven settings writes, reset hold and save traffic,
// checked against a reference model of the save contents

`default_nettype none

`include "core_cfg.svh"

module core_top_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int SAVE_TIMEOUT = 200;
  localparam int LOCK_TIMEOUT = 50;
  localparam int SAVE_WORDS = 1 << (`SAVE_ADDR_WIDTH - 1);
  localparam logic [31:0] SAVE_BYTES = 32'(1 << (`SAVE_ADDR_WIDTH + 1));

  typedef enum logic [2:0] {
    OP_IDLE_CHECK,
    OP_SET_WR,
    OP_SAVE_WR,
    OP_SAVE_RD,
    OP_RESET_CMD
  } op_kind_t;

  typedef struct packed {
    logic [3:0]  test;
    op_kind_t    kind;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expect_v;
    logic        no_wait;
  } entry_t;

  logic clk_74a;
  logic pll_core_locked;
  core_pkg::bridge_addr_t bridge_addr;
  logic bridge_rd;
  logic bridge_wr;
  core_pkg::bridge_word_t bridge_wr_data;
  core_pkg::bridge_word_t bridge_rd_data;
  logic is_sgx;
  logic turbo_tap_enable;
  logic overscan_enable;
  logic extra_sprites_enable;
  logic core_reset;
  logic save_busy;

  entry_t tbl[$];
  logic [31:0] ref_mem [SAVE_WORDS];
  // {extra_sprites, overscan, turbo_tap, sgx}
  logic [3:0] flags_model;
  logic [31:0] rng_state;
  int errors;
  int tests_passed;
  int tests_failed;

  tb_clock u_clock (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked)
  );

  core_top u_dut (
    .clk_74a              (clk_74a),
    .pll_core_locked      (pll_core_locked),
    .bridge_addr          (bridge_addr),
    .bridge_rd            (bridge_rd),
    .bridge_wr            (bridge_wr),
    .bridge_wr_data       (bridge_wr_data),
    .bridge_rd_data       (bridge_rd_data),
    .is_sgx               (is_sgx),
    .turbo_tap_enable     (turbo_tap_enable),
    .overscan_enable      (overscan_enable),
    .extra_sprites_enable (extra_sprites_enable),
    .core_reset           (core_reset),
    .save_busy            (save_busy)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // word offset wraps at the buffer size
  function automatic logic [`SAVE_ADDR_WIDTH-2:0] word_index(input logic [31:0] addr);
    return addr[`SAVE_ADDR_WIDTH:2];
  endfunction

  function automatic logic [31:0] save_addr(input logic [7:0] offset);
    return {`SAVE_REGION, 28'h0} | {22'h0, offset, 2'b00};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  ////////////////////
  // table building with expected values from the bridge rules
  task automatic enqueue_setting(input logic [3:0] t, input logic [31:0] addr,
                                 input logic [31:0] data);
    entry_t e;
    case (addr)
      `ADDR_SGX:           flags_model[0] = data[0];
      `ADDR_TURBO_TAP:     flags_model[1] = data[0];
      `ADDR_OVERSCAN:      flags_model[2] = data[0];
      `ADDR_EXTRA_SPRITES: flags_model[3] = data[0];
      default: ;
    endcase
    e = '{t, OP_SET_WR, addr, data, {28'h0, flags_model}, 1'b0};
    tbl.push_back(e);
  endtask

  task automatic schedule_save_write(input logic [3:0] t, input logic [31:0] addr,
                                     input logic no_wait);
    entry_t e;
    rng_state = xorshift32(rng_state);
    ref_mem[word_index(addr)] = rng_state;
    e = '{t, OP_SAVE_WR, addr, rng_state, 32'h0, no_wait};
    tbl.push_back(e);
  endtask

  task automatic expect_save_read(input logic [3:0] t, input logic [31:0] addr);
    entry_t e;
    logic [31:0] exp;
    exp = (addr[31:28] == `SAVE_REGION) ? ref_mem[word_index(addr)] : 32'h0;
    e = '{t, OP_SAVE_RD, addr, 32'h0, exp, 1'b0};
    tbl.push_back(e);
  endtask

  task automatic build_table();
    entry_t e;
    logic [31:0] first_addr;
    logic [31:0] a;
    int i;
    e = '{4'd1, OP_IDLE_CHECK, save_addr(8'h10), 32'h0, 32'h0, 1'b0};
    tbl.push_back(e);
    enqueue_setting(4'd2, `ADDR_SGX, 32'h1);
    enqueue_setting(4'd2, `ADDR_TURBO_TAP, 32'h3);
    enqueue_setting(4'd2, `ADDR_OVERSCAN, 32'h1);
    enqueue_setting(4'd2, `ADDR_EXTRA_SPRITES, 32'hffff_ffff);
    enqueue_setting(4'd2, 32'h0000_0008, 32'h0);
    enqueue_setting(4'd2, 32'h1000_0100, 32'h0);
    enqueue_setting(4'd2, `ADDR_SGX, 32'h2);
    enqueue_setting(4'd2, `ADDR_OVERSCAN, 32'h0);
    e = '{4'd3, OP_RESET_CMD, `ADDR_RESET, 32'h1, 32'h0, 1'b0};
    tbl.push_back(e);
    first_addr = 32'h0;
    for (i = 0; i < 8; i++) begin
      rng_state = xorshift32(rng_state);
      a = save_addr(rng_state[7:0]);
      if (i == 0) begin
        first_addr = a;
      end
      schedule_save_write(4'd4, a, 1'b0);
      expect_save_read(4'd4, a);
    end
    expect_save_read(4'd4, 32'h1000_0010);
    expect_save_read(4'd4, `ADDR_SGX);
    // write still in flight when the read arrives
    schedule_save_write(4'd5, first_addr ^ 32'h4, 1'b1);
    expect_save_read(4'd5, first_addr);
    expect_save_read(4'd5, first_addr ^ 32'h4);
    schedule_save_write(4'd6, save_addr(8'h08), 1'b0);
    schedule_save_write(4'd6, save_addr(8'h08) + SAVE_BYTES, 1'b0);
    expect_save_read(4'd6, save_addr(8'h08));
    expect_save_read(4'd6, save_addr(8'h08) + SAVE_BYTES);
  endtask

  ////////////////////
  // driving and waiting
  task automatic wait_save_idle();
    int n;
    n = 0;
    while (save_busy && n < SAVE_TIMEOUT) begin
      @(negedge clk_74a);
      n++;
    end
    if (save_busy) begin
      $display("save path still busy after %0d cycles", n);
      errors++;
    end
  endtask

  task automatic apply_entry(input entry_t e);
    int n;
    bridge_addr = e.addr;
    bridge_wr_data = e.data;
    case (e.kind)
      OP_IDLE_CHECK: begin
        @(negedge clk_74a);
        check_value("settings flags", {28'h0, extra_sprites_enable, overscan_enable,
                    turbo_tap_enable, is_sgx}, 32'h0);
        check_value("core_reset", {31'h0, core_reset}, 32'h0);
        check_value("save_busy", {31'h0, save_busy}, 32'h0);
        check_value("bridge_rd_data", bridge_rd_data, 32'h0);
      end
      OP_SET_WR: begin
        bridge_wr = 1'b1;
        @(negedge clk_74a);
        bridge_wr = 1'b0;
        check_value("is_sgx", {31'h0, is_sgx}, {31'h0, e.expect_v[0]});
        check_value("turbo_tap_enable", {31'h0, turbo_tap_enable}, {31'h0, e.expect_v[1]});
        check_value("overscan_enable", {31'h0, overscan_enable}, {31'h0, e.expect_v[2]});
        check_value("extra_sprites_enable", {31'h0, extra_sprites_enable},
                    {31'h0, e.expect_v[3]});
      end
      OP_SAVE_WR: begin
        bridge_wr = 1'b1;
        @(negedge clk_74a);
        bridge_wr = 1'b0;
        check_value("save_busy", {31'h0, save_busy}, 32'h1);
        if (!e.no_wait) begin
          wait_save_idle();
        end
      end
      OP_SAVE_RD: begin
        bridge_rd = 1'b1;
        @(negedge clk_74a);
        bridge_rd = 1'b0;
        wait_save_idle();
        check_value("bridge_rd_data", bridge_rd_data, e.expect_v);
      end
      default: begin
        bridge_wr = 1'b1;
        @(negedge clk_74a);
        bridge_wr = 1'b0;
        check_value("core_reset", {31'h0, core_reset}, 32'h1);
        n = 0;
        while (core_reset && n < int'(`RESET_HOLD_CYCLES) + 2) begin
          @(negedge clk_74a);
          n++;
        end
        if (core_reset) begin
          $display("core_reset still high %0d cycles after the reset command", n);
          errors++;
        end else begin
          // high from the cycle after the command for the full hold length
          check_value("core_reset hold cycles", n, `RESET_HOLD_CYCLES);
        end
      end
    endcase
  endtask

  task automatic report_test(input logic [3:0] t, input int errs);
    if (errs == 0) begin
      $display("test %0d passed", t);
      tests_passed++;
    end else begin
      $display("test %0d failed with %0d errors", t, errs);
      tests_failed++;
    end
  endtask

  initial begin
    int n;
    int i;
    int errs_before;
    int assert_fails;
    bridge_addr = '0;
    bridge_rd = 1'b0;
    bridge_wr = 1'b0;
    bridge_wr_data = '0;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    errs_before = 0;
    flags_model = 4'h0;
    rng_state = 32'h8c671d42;
    build_table();

    n = 0;
    while (!pll_core_locked && n < LOCK_TIMEOUT) begin
      @(negedge clk_74a);
      n++;
    end
    if (!pll_core_locked) begin
      $display("pll_core_locked never went high");
      errors++;
    end
    @(negedge clk_74a);

    for (i = 0; i < tbl.size(); i++) begin
      if (i == 0 || tbl[i].test != tbl[i-1].test) begin
        errs_before = errors;
      end
      apply_entry(tbl[i]);
      if (i == tbl.size() - 1 || tbl[i+1].test != tbl[i].test) begin
        report_test(tbl[i].test, errors - errs_before);
      end
    end

    repeat (4) @(negedge clk_74a);
    assert_fails = u_dut.u_arbiter.u_assert.fail_count;
    $display("%0d tests passed, %0d failed, %0d check errors, %0d assertion failures",
             tests_passed, tests_failed, errors, assert_fails);
    if (errors == 0 && tests_failed == 0 && assert_fails == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+hw
hw/core_pkg.sv
hw/bridge_settings.sv
hw/save_loader.sv
hw/save_unloader.sv
hw/save_arbiter.sv
hw/save_buffer.sv
hw/core_top.sv
tb/tb_clock.sv
tb/core_top_assert.sv
tb/core_top_tb.sv

/* Makefile */
# Verilator simulation of the core top level testbench

VERILATOR ?= verilator
TOP       ?= core_top_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	-$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
